//--- design/rename_pkg.sv
package rename_pkg;

    // datapath and register file size
    localparam int xlen     = 32;
    localparam int num_regs = 32;

    // accepted major opcodes
    localparam logic [6:0] opcode_op     = 7'b0110011;
    localparam logic [6:0] opcode_op_imm = 7'b0010011;

    // alu lane op codes
    localparam logic [2:0] alu_add = 3'd0;
    localparam logic [2:0] alu_sub = 3'd1;
    localparam logic [2:0] alu_xor = 3'd2;
    localparam logic [2:0] alu_or  = 3'd3;
    localparam logic [2:0] alu_and = 3'd4;
    localparam logic [2:0] alu_sll = 3'd5;
    localparam logic [2:0] alu_srl = 3'd6;

    // one instruction word, seen as r-type or as i-type
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm12;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
    } instr_word_u;

endpackage

//--- design/instr_decode.sv
module instr_decode (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       instr_valid,
    input  logic [31:0]                instr_word,
    input  logic [rename_pkg::xlen-1:0] instr_pc,
    input  logic                       stall,
    output logic                       dec_valid,
    output logic [4:0]                 dec_rd,
    output logic [4:0]                 dec_rs1,
    output logic [4:0]                 dec_rs2,
    output logic                       dec_use_imm,
    output logic [rename_pkg::xlen-1:0] dec_imm,
    output logic [2:0]                 dec_op,
    output logic                       dec_is_mul,
    output logic [rename_pkg::xlen-1:0] dec_pc
);

    rename_pkg::instr_word_u iw;
    logic                    legal;
    logic                    f3_ok;
    logic                    use_imm;
    logic                    is_mul;
    logic [2:0]              op;

    assign iw = instr_word;

    always_comb begin
        legal   = 1'b0;
        f3_ok   = 1'b1;
        use_imm = 1'b0;
        is_mul  = 1'b0;
        // funct3 picks the basic alu function
        case (iw.r.funct3)
            3'b000:  op = rename_pkg::alu_add;
            3'b100:  op = rename_pkg::alu_xor;
            3'b110:  op = rename_pkg::alu_or;
            3'b111:  op = rename_pkg::alu_and;
            3'b001:  op = rename_pkg::alu_sll;
            3'b101:  op = rename_pkg::alu_srl;
            default: begin
                op    = rename_pkg::alu_add;
                f3_ok = 1'b0;
            end
        endcase
        if (iw.r.opcode == rename_pkg::opcode_op) begin
            if (iw.r.funct7 == 7'b0000000) begin
                legal = f3_ok;
            end else if (iw.r.funct7 == 7'b0100000 && iw.r.funct3 == 3'b000) begin
                legal = 1'b1;
                op    = rename_pkg::alu_sub;
            end else if (iw.r.funct7 == 7'b0000001 && iw.r.funct3 == 3'b000) begin
                // mul, low half only
                legal  = 1'b1;
                is_mul = 1'b1;
            end
        end else if (iw.i.opcode == rename_pkg::opcode_op_imm) begin
            // no immediate shifts in this subset
            legal   = f3_ok && iw.i.funct3 != 3'b001 && iw.i.funct3 != 3'b101;
            use_imm = 1'b1;
        end
    end

    // valid bit, held during stall
    always_ff @(posedge clk) begin
        if (rst) begin
            dec_valid <= 1'b0;
        end else if (!stall) begin
            dec_valid <= instr_valid && legal;
        end
    end

    // decoded payload
    always_ff @(posedge clk) begin
        if (!stall) begin
            dec_rd      <= iw.r.rd;
            dec_rs1     <= iw.r.rs1;
            // i-type has no second source, x0 is always ready
            dec_rs2     <= use_imm ? 5'd0 : iw.r.rs2;
            dec_use_imm <= use_imm;
            dec_imm     <= {{(rename_pkg::xlen-12){iw.i.imm12[11]}}, iw.i.imm12};
            dec_op      <= op;
            dec_is_mul  <= is_mul;
            dec_pc      <= instr_pc;
        end
    end

endmodule

//--- design/rat_arf.sv
module rat_arf #(
    parameter int ROB_DEPTH = 8
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [4:0]                  rs1,
    input  logic [4:0]                  rs2,
    input  logic                        rename_en,
    input  logic [4:0]                  rename_rd,
    input  logic [$clog2(ROB_DEPTH)-1:0] rename_tag,
    input  logic                        commit_valid,
    input  logic [4:0]                  commit_rd,
    input  logic [$clog2(ROB_DEPTH)-1:0] commit_tag,
    input  logic [rename_pkg::xlen-1:0] commit_data,
    output logic                        rs1_ready,
    output logic [$clog2(ROB_DEPTH)-1:0] rs1_tag,
    output logic [rename_pkg::xlen-1:0] rs1_value,
    output logic                        rs2_ready,
    output logic [$clog2(ROB_DEPTH)-1:0] rs2_tag,
    output logic [rename_pkg::xlen-1:0] rs2_value
);

    localparam int TAG_W = $clog2(ROB_DEPTH);

    // per register: committed value, ready flag, newest producer
    logic [rename_pkg::xlen-1:0] value [rename_pkg::num_regs];
    logic                        ready [rename_pkg::num_regs];
    logic [TAG_W-1:0]            tag   [rename_pkg::num_regs];

    // read ports for dispatch
    assign rs1_ready = ready[rs1];
    assign rs1_tag   = tag[rs1];
    assign rs1_value = value[rs1];
    assign rs2_ready = ready[rs2];
    assign rs2_tag   = tag[rs2];
    assign rs2_value = value[rs2];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < rename_pkg::num_regs; i++) begin
                value[i] <= '0;
                ready[i] <= 1'b1;
                tag[i]   <= '0;
            end
        end else begin
            // only the newest producer may make the register ready again
            if (commit_valid && commit_rd != 5'd0 && tag[commit_rd] == commit_tag) begin
                value[commit_rd] <= commit_data;
                ready[commit_rd] <= 1'b1;
            end
            // rename comes last so it overrides a same-cycle commit
            if (rename_en && rename_rd != 5'd0) begin
                ready[rename_rd] <= 1'b0;
                tag[rename_rd]   <= rename_tag;
            end
        end
    end

endmodule

//--- design/dispatch_stage.sv
module dispatch_stage #(
    parameter int ROB_DEPTH = 8
) (
    input  logic                        dec_valid,
    input  logic [4:0]                  dec_rd,
    input  logic [4:0]                  dec_rs1,
    input  logic [4:0]                  dec_rs2,
    input  logic                        dec_use_imm,
    input  logic [rename_pkg::xlen-1:0] dec_imm,
    input  logic [2:0]                  dec_op,
    input  logic                        dec_is_mul,
    input  logic [rename_pkg::xlen-1:0] dec_pc,
    input  logic                        rs1_ready,
    input  logic [$clog2(ROB_DEPTH)-1:0] rs1_tag,
    input  logic [rename_pkg::xlen-1:0] rs1_value,
    input  logic                        rs2_ready,
    input  logic [$clog2(ROB_DEPTH)-1:0] rs2_tag,
    input  logic [rename_pkg::xlen-1:0] rs2_value,
    input  logic                        rob_full,
    input  logic                        src1_done,
    input  logic [rename_pkg::xlen-1:0] src1_value,
    input  logic                        src2_done,
    input  logic [rename_pkg::xlen-1:0] src2_value,
    input  logic [$clog2(ROB_DEPTH)-1:0] alloc_tag,
    output logic [$clog2(ROB_DEPTH)-1:0] src1_tag,
    output logic [$clog2(ROB_DEPTH)-1:0] src2_tag,
    output logic                        stall,
    output logic                        disp_valid,
    output logic [4:0]                  disp_rd,
    output logic [rename_pkg::xlen-1:0] disp_pc,
    output logic [2:0]                  disp_op,
    output logic                        disp_is_mul,
    output logic [$clog2(ROB_DEPTH)-1:0] disp_tag,
    output logic [rename_pkg::xlen-1:0] opa,
    output logic [rename_pkg::xlen-1:0] opb
);

    logic avail1;
    logic avail2;

    // rob lookup uses the producer tag from the rename table
    assign src1_tag = rs1_tag;
    assign src2_tag = rs2_tag;

    // x0, committed register or finished rob entry
    assign avail1 = dec_rs1 == 5'd0 || rs1_ready || src1_done;
    assign avail2 = dec_use_imm || dec_rs2 == 5'd0 || rs2_ready || src2_done;

    always_comb begin
        if (dec_rs1 == 5'd0) begin
            opa = '0;
        end else if (rs1_ready) begin
            opa = rs1_value;
        end else begin
            opa = src1_value;
        end
        // immediate replaces the second source
        if (dec_use_imm) begin
            opb = dec_imm;
        end else if (dec_rs2 == 5'd0) begin
            opb = '0;
        end else if (rs2_ready) begin
            opb = rs2_value;
        end else begin
            opb = src2_value;
        end
    end

    // stall only while a real instruction waits
    assign stall      = dec_valid && (!avail1 || !avail2 || rob_full);
    assign disp_valid = dec_valid && !stall;

    assign disp_rd     = dec_rd;
    assign disp_pc     = dec_pc;
    assign disp_op     = dec_op;
    assign disp_is_mul = dec_is_mul;
    // tag is simply the rob tail slot
    assign disp_tag    = alloc_tag;

endmodule

//--- design/exec_units.sv
module exec_units #(
    parameter int ROB_DEPTH   = 8,
    parameter int MUL_LATENCY = 3
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        disp_valid,
    input  logic                        disp_is_mul,
    input  logic [2:0]                  disp_op,
    input  logic [$clog2(ROB_DEPTH)-1:0] disp_tag,
    input  logic [rename_pkg::xlen-1:0] opa,
    input  logic [rename_pkg::xlen-1:0] opb,
    output logic                        alu_done,
    output logic [$clog2(ROB_DEPTH)-1:0] alu_tag,
    output logic [rename_pkg::xlen-1:0] alu_value,
    output logic                        mul_done,
    output logic [$clog2(ROB_DEPTH)-1:0] mul_tag,
    output logic [rename_pkg::xlen-1:0] mul_value
);

    localparam int TAG_W = $clog2(ROB_DEPTH);

    logic [rename_pkg::xlen-1:0] alu_res;
    logic [rename_pkg::xlen-1:0] prod;
    // multiply pipe stages
    logic                        mv [MUL_LATENCY];
    logic [TAG_W-1:0]            mt [MUL_LATENCY];
    logic [rename_pkg::xlen-1:0] mp [MUL_LATENCY];

    always_comb begin
        case (disp_op)
            rename_pkg::alu_sub: alu_res = opa - opb;
            rename_pkg::alu_xor: alu_res = opa ^ opb;
            rename_pkg::alu_or:  alu_res = opa | opb;
            rename_pkg::alu_and: alu_res = opa & opb;
            // shift amount is the low five bits
            rename_pkg::alu_sll: alu_res = opa << opb[4:0];
            rename_pkg::alu_srl: alu_res = opa >> opb[4:0];
            default:             alu_res = opa + opb;
        endcase
    end

    // low half of the product
    assign prod = opa * opb;

    always_ff @(posedge clk) begin
        if (rst) begin
            alu_done <= 1'b0;
            for (int s = 0; s < MUL_LATENCY; s++) begin
                mv[s] <= 1'b0;
            end
        end else begin
            alu_done <= disp_valid && !disp_is_mul;
            mv[0]    <= disp_valid && disp_is_mul;
            for (int s = 1; s < MUL_LATENCY; s++) begin
                mv[s] <= mv[s-1];
            end
        end
    end

    // payload moves along with the valid bits
    always_ff @(posedge clk) begin
        alu_tag   <= disp_tag;
        alu_value <= alu_res;
        mt[0]     <= disp_tag;
        mp[0]     <= prod;
        for (int s = 1; s < MUL_LATENCY; s++) begin
            mt[s] <= mt[s-1];
            mp[s] <= mp[s-1];
        end
    end

    assign mul_done  = mv[MUL_LATENCY-1];
    assign mul_tag   = mt[MUL_LATENCY-1];
    assign mul_value = mp[MUL_LATENCY-1];

endmodule

//--- design/reorder_buffer.sv
module reorder_buffer #(
    parameter int ROB_DEPTH = 8
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        alloc_en,
    input  logic [4:0]                  alloc_rd,
    input  logic [rename_pkg::xlen-1:0] alloc_pc,
    input  logic [$clog2(ROB_DEPTH)-1:0] src1_tag,
    input  logic [$clog2(ROB_DEPTH)-1:0] src2_tag,
    input  logic                        alu_done,
    input  logic [$clog2(ROB_DEPTH)-1:0] alu_tag,
    input  logic [rename_pkg::xlen-1:0] alu_value,
    input  logic                        mul_done,
    input  logic [$clog2(ROB_DEPTH)-1:0] mul_tag,
    input  logic [rename_pkg::xlen-1:0] mul_value,
    output logic [$clog2(ROB_DEPTH)-1:0] alloc_tag,
    output logic                        rob_full,
    output logic                        src1_done,
    output logic [rename_pkg::xlen-1:0] src1_value,
    output logic                        src2_done,
    output logic [rename_pkg::xlen-1:0] src2_value,
    output logic                        commit_valid,
    output logic [4:0]                  commit_rd,
    output logic [rename_pkg::xlen-1:0] commit_data,
    output logic [rename_pkg::xlen-1:0] commit_pc,
    output logic [$clog2(ROB_DEPTH)-1:0] commit_tag
);

    localparam int TAG_W = $clog2(ROB_DEPTH);

    logic [4:0]                  rd    [ROB_DEPTH];
    logic [rename_pkg::xlen-1:0] pc    [ROB_DEPTH];
    logic [rename_pkg::xlen-1:0] value [ROB_DEPTH];
    logic                        done  [ROB_DEPTH];
    logic [TAG_W-1:0]            head;
    logic [TAG_W-1:0]            tail;
    logic [TAG_W:0]              count;
    logic                        do_commit;

    assign alloc_tag = tail;
    assign rob_full  = count == (TAG_W+1)'(ROB_DEPTH);
    // head retires once its result is in
    assign do_commit = count != '0 && done[head];

    // operand lookup, sees done one cycle after completion
    assign src1_done  = done[src1_tag];
    assign src1_value = value[src1_tag];
    assign src2_done  = done[src2_tag];
    assign src2_value = value[src2_tag];

    always_ff @(posedge clk) begin
        if (rst) begin
            head         <= '0;
            tail         <= '0;
            count        <= '0;
            commit_valid <= 1'b0;
            for (int i = 0; i < ROB_DEPTH; i++) begin
                done[i] <= 1'b0;
            end
        end else begin
            commit_valid <= do_commit;
            if (do_commit) begin
                head <= head + 1'b1;
            end
            if (alloc_en) begin
                done[tail] <= 1'b0;
                tail       <= tail + 1'b1;
            end
            // completion ports never target the tail slot
            if (alu_done) begin
                done[alu_tag] <= 1'b1;
            end
            if (mul_done) begin
                done[mul_tag] <= 1'b1;
            end
            count <= count + (TAG_W+1)'(alloc_en) - (TAG_W+1)'(do_commit);
        end
    end

    // entry payload and commit outputs
    always_ff @(posedge clk) begin
        if (alloc_en) begin
            rd[tail] <= alloc_rd;
            pc[tail] <= alloc_pc;
        end
        if (alu_done) begin
            value[alu_tag] <= alu_value;
        end
        if (mul_done) begin
            value[mul_tag] <= mul_value;
        end
        commit_rd   <= rd[head];
        commit_data <= value[head];
        commit_pc   <= pc[head];
        commit_tag  <= head;
    end

endmodule

//--- design/rename_core_top.sv
module rename_core_top #(
    parameter int ROB_DEPTH   = 8,
    parameter int MUL_LATENCY = 3
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        instr_valid,
    input  logic [31:0]                 instr_word,
    input  logic [rename_pkg::xlen-1:0] instr_pc,
    output logic                        stall,
    output logic                        commit_valid,
    output logic [4:0]                  commit_rd,
    output logic [rename_pkg::xlen-1:0] commit_data,
    output logic [rename_pkg::xlen-1:0] commit_pc
);

    localparam int TAG_W = $clog2(ROB_DEPTH);
    localparam int XW    = rename_pkg::xlen;

    // decode to dispatch
    logic          dec_valid, dec_use_imm, dec_is_mul;
    logic [4:0]    dec_rd, dec_rs1, dec_rs2;
    logic [XW-1:0] dec_imm, dec_pc;
    logic [2:0]    dec_op;
    // rename table read ports
    logic             rs1_ready, rs2_ready;
    logic [TAG_W-1:0] rs1_tag, rs2_tag;
    logic [XW-1:0]    rs1_value, rs2_value;
    // rob lookup and allocation
    logic             rob_full, src1_done, src2_done;
    logic [TAG_W-1:0] src1_tag, src2_tag, alloc_tag, commit_tag;
    logic [XW-1:0]    src1_value, src2_value;
    // dispatch to lanes
    logic             disp_valid, disp_is_mul;
    logic [4:0]       disp_rd;
    logic [XW-1:0]    disp_pc, opa, opb;
    logic [2:0]       disp_op;
    logic [TAG_W-1:0] disp_tag;
    // completion ports
    logic             alu_done, mul_done;
    logic [TAG_W-1:0] alu_tag, mul_tag;
    logic [XW-1:0]    alu_value, mul_value;

    instr_decode u_instr_decode (
        .clk(clk), .rst(rst), .instr_valid(instr_valid), .instr_word(instr_word),
        .instr_pc(instr_pc), .stall(stall), .dec_valid(dec_valid), .dec_rd(dec_rd),
        .dec_rs1(dec_rs1), .dec_rs2(dec_rs2), .dec_use_imm(dec_use_imm), .dec_imm(dec_imm),
        .dec_op(dec_op), .dec_is_mul(dec_is_mul), .dec_pc(dec_pc)
    );

    rat_arf #(.ROB_DEPTH(ROB_DEPTH)) u_rat_arf (
        .clk(clk), .rst(rst), .rs1(dec_rs1), .rs2(dec_rs2),
        .rename_en(disp_valid), .rename_rd(disp_rd), .rename_tag(disp_tag),
        .commit_valid(commit_valid), .commit_rd(commit_rd), .commit_tag(commit_tag),
        .commit_data(commit_data), .rs1_ready(rs1_ready), .rs1_tag(rs1_tag),
        .rs1_value(rs1_value), .rs2_ready(rs2_ready), .rs2_tag(rs2_tag), .rs2_value(rs2_value)
    );

    dispatch_stage #(.ROB_DEPTH(ROB_DEPTH)) u_dispatch_stage (
        .dec_valid(dec_valid), .dec_rd(dec_rd), .dec_rs1(dec_rs1), .dec_rs2(dec_rs2),
        .dec_use_imm(dec_use_imm), .dec_imm(dec_imm), .dec_op(dec_op),
        .dec_is_mul(dec_is_mul), .dec_pc(dec_pc), .rs1_ready(rs1_ready), .rs1_tag(rs1_tag),
        .rs1_value(rs1_value), .rs2_ready(rs2_ready), .rs2_tag(rs2_tag),
        .rs2_value(rs2_value), .rob_full(rob_full), .src1_done(src1_done),
        .src1_value(src1_value), .src2_done(src2_done), .src2_value(src2_value),
        .alloc_tag(alloc_tag), .src1_tag(src1_tag), .src2_tag(src2_tag), .stall(stall),
        .disp_valid(disp_valid), .disp_rd(disp_rd), .disp_pc(disp_pc), .disp_op(disp_op),
        .disp_is_mul(disp_is_mul), .disp_tag(disp_tag), .opa(opa), .opb(opb)
    );

    exec_units #(.ROB_DEPTH(ROB_DEPTH), .MUL_LATENCY(MUL_LATENCY)) u_exec_units (
        .clk(clk), .rst(rst), .disp_valid(disp_valid), .disp_is_mul(disp_is_mul),
        .disp_op(disp_op), .disp_tag(disp_tag), .opa(opa), .opb(opb),
        .alu_done(alu_done), .alu_tag(alu_tag), .alu_value(alu_value),
        .mul_done(mul_done), .mul_tag(mul_tag), .mul_value(mul_value)
    );

    reorder_buffer #(.ROB_DEPTH(ROB_DEPTH)) u_reorder_buffer (
        .clk(clk), .rst(rst), .alloc_en(disp_valid), .alloc_rd(disp_rd),
        .alloc_pc(disp_pc), .src1_tag(src1_tag), .src2_tag(src2_tag),
        .alu_done(alu_done), .alu_tag(alu_tag), .alu_value(alu_value),
        .mul_done(mul_done), .mul_tag(mul_tag), .mul_value(mul_value),
        .alloc_tag(alloc_tag), .rob_full(rob_full), .src1_done(src1_done),
        .src1_value(src1_value), .src2_done(src2_done), .src2_value(src2_value),
        .commit_valid(commit_valid), .commit_rd(commit_rd), .commit_data(commit_data),
        .commit_pc(commit_pc), .commit_tag(commit_tag)
    );

endmodule

//--- verification/rename_core_assert.sv
module rename_core_assert #(
    parameter int ROB_DEPTH = 8
) (
    input logic                         clk,
    input logic                         rst,
    input logic [$clog2(ROB_DEPTH):0]   count,
    input logic                         alloc_en,
    input logic [$clog2(ROB_DEPTH)-1:0] alloc_tag,
    input logic                         rob_full,
    input logic                         alu_done,
    input logic [$clog2(ROB_DEPTH)-1:0] alu_tag,
    input logic                         mul_done,
    input logic [$clog2(ROB_DEPTH)-1:0] mul_tag,
    input logic                         commit_valid,
    input logic [$clog2(ROB_DEPTH)-1:0] commit_tag
);

    localparam int TAG_W = $clog2(ROB_DEPTH);

    // finished flags seen from the completion ports
    logic [ROB_DEPTH-1:0] fin;
    // same flags one cycle later
    logic [ROB_DEPTH-1:0] fin_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            fin   <= '0;
            fin_q <= '0;
        end else begin
            fin_q <= fin;
            if (alloc_en) begin
                fin[alloc_tag] <= 1'b0;
            end
            if (alu_done) begin
                fin[alu_tag] <= 1'b1;
            end
            if (mul_done) begin
                fin[mul_tag] <= 1'b1;
            end
        end
    end

    // occupancy stays within the ring
    count_bound: assert property (@(posedge clk) disable iff (rst)
        count <= (TAG_W+1)'(ROB_DEPTH))
        else $error("rob count above depth");

    // committed entry had finished before its head cycle
    commit_after_done: assert property (@(posedge clk) disable iff (rst)
        commit_valid |-> fin_q[commit_tag])
        else $error("commit without a finished head entry");

    no_alloc_when_full: assert property (@(posedge clk) disable iff (rst)
        !(alloc_en && rob_full))
        else $error("allocation into a full rob");

endmodule

bind reorder_buffer rename_core_assert #(.ROB_DEPTH(ROB_DEPTH)) u_rename_core_assert (
    .clk(clk), .rst(rst), .count(count), .alloc_en(alloc_en), .alloc_tag(alloc_tag),
    .rob_full(rob_full), .alu_done(alu_done), .alu_tag(alu_tag), .mul_done(mul_done),
    .mul_tag(mul_tag), .commit_valid(commit_valid), .commit_tag(commit_tag)
);

//--- verification/rename_core_tb.sv
module rename_core_tb;

    localparam int ROB_DEPTH   = 4;
    localparam int MUL_LATENCY = 3;
    localparam int WAIT_LIMIT  = 200;

    logic        clk;
    logic        rst;
    logic        instr_valid;
    logic [31:0] instr_word;
    logic [31:0] instr_pc;
    logic        stall;
    logic        commit_valid;
    logic [4:0]  commit_rd;
    logic [31:0] commit_data;
    logic [31:0] commit_pc;

    // isa register model and expected commit stream
    logic [31:0] regs [32];
    logic [4:0]  exp_rd  [$];
    logic [31:0] exp_val [$];
    logic [31:0] exp_pc  [$];
    logic [31:0] next_pc;
    int          value_errors;
    int          other_errors;
    int          timeouts;
    int          legal_count;
    int          commit_count;
    int          stall_cycles;
    int          stall_before;

    rename_core_top #(.ROB_DEPTH(ROB_DEPTH), .MUL_LATENCY(MUL_LATENCY)) u_rename_core_top (
        .clk(clk), .rst(rst), .instr_valid(instr_valid), .instr_word(instr_word),
        .instr_pc(instr_pc), .stall(stall), .commit_valid(commit_valid),
        .commit_rd(commit_rd), .commit_data(commit_data), .commit_pc(commit_pc)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'h33};
    endfunction

    function automatic logic [31:0] i_word(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, 7'h13};
    endfunction

    // sequential isa result, returns 0 for words outside the subset
    function automatic logic ref_exec(input logic [31:0] w, output logic [31:0] res);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic        legal;
        a     = regs[w[19:15]];
        b     = regs[w[24:20]];
        imm   = {{20{w[31]}}, w[31:20]};
        legal = 1'b1;
        res   = '0;
        if (w[6:0] == 7'h33 && w[31:25] == 7'h00) begin
            case (w[14:12])
                3'd0:    res = a + b;
                3'd1:    res = a << b[4:0];
                3'd4:    res = a ^ b;
                3'd5:    res = a >> b[4:0];
                3'd6:    res = a | b;
                3'd7:    res = a & b;
                default: legal = 1'b0;
            endcase
        end else if (w[6:0] == 7'h33 && w[31:25] == 7'h20 && w[14:12] == 3'd0) begin
            res = a - b;
        end else if (w[6:0] == 7'h33 && w[31:25] == 7'h01 && w[14:12] == 3'd0) begin
            // low word of the product
            res = a * b;
        end else if (w[6:0] == 7'h13) begin
            case (w[14:12])
                3'd0:    res = a + imm;
                3'd4:    res = a ^ imm;
                3'd6:    res = a | imm;
                3'd7:    res = a & imm;
                default: legal = 1'b0;
            endcase
        end else begin
            legal = 1'b0;
        end
        return legal;
    endfunction

    // mix of legal ops and dropped encodings over x0..x7
    function automatic logic [31:0] rand_word();
        int         sel;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [6:0] f7;
        logic [2:0] f3;
        sel = int'($urandom % 10);
        rd  = 5'($urandom % 8);
        rs1 = 5'($urandom % 8);
        rs2 = 5'($urandom % 8);
        if (sel < 4) begin
            case ($urandom % 8)
                0:       {f7, f3} = {7'h00, 3'd0};
                1:       {f7, f3} = {7'h20, 3'd0};
                2:       {f7, f3} = {7'h00, 3'd4};
                3:       {f7, f3} = {7'h00, 3'd6};
                4:       {f7, f3} = {7'h00, 3'd7};
                5:       {f7, f3} = {7'h00, 3'd1};
                6:       {f7, f3} = {7'h00, 3'd5};
                default: {f7, f3} = {7'h01, 3'd0};
            endcase
            return r_word(f7, rs2, rs1, f3, rd);
        end else if (sel < 7) begin
            f3 = 3'($urandom % 4);
            // 0 addi, 4 xori, 6 ori, 7 andi
            f3 = (f3 == 3'd0) ? 3'd0 : f3 + 3'd3 + ((f3 == 3'd1) ? 3'd0 : 3'd1);
            return i_word(12'($urandom), rs1, f3, rd);
        end else if (sel == 7) begin
            // slt, sra, mulh
            case ($urandom % 3)
                0:       return r_word(7'h00, rs2, rs1, 3'd2, rd);
                1:       return r_word(7'h20, rs2, rs1, 3'd5, rd);
                default: return r_word(7'h01, rs2, rs1, 3'd1, rd);
            endcase
        end else if (sel == 8) begin
            // slli, then a load opcode
            if ($urandom % 2 == 0) begin
                return i_word(12'd3, rs1, 3'd1, rd);
            end
            return {12'd4, rs1, 3'd2, rd, 7'h03};
        end
        return $urandom;
    endfunction

    task automatic record(input logic [31:0] w, input logic [31:0] pc);
        logic [31:0] res;
        if (ref_exec(w, res)) begin
            // x0 commits its rd but the model keeps zero
            if (w[11:7] != 5'd0) begin
                regs[w[11:7]] = res;
            end
            exp_rd.push_back(w[11:7]);
            exp_val.push_back(res);
            exp_pc.push_back(pc);
            legal_count++;
        end
    endtask

    task automatic send(input logic [31:0] w);
        int waited;
        @(negedge clk);
        instr_valid = 1'b1;
        instr_word  = w;
        instr_pc    = next_pc;
        waited      = 0;
        // word is held until a cycle with stall low
        while (stall && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (stall) begin
            timeouts++;
            $display("timeout: word %h at pc %h was never accepted", w, next_pc);
        end else begin
            record(w, next_pc);
        end
        next_pc = next_pc + 32'd4;
    endtask

    task automatic drain();
        int waited;
        @(negedge clk);
        instr_valid = 1'b0;
        waited      = 0;
        while (exp_pc.size() != 0 && waited < 1000) begin
            @(negedge clk);
            waited++;
        end
        if (exp_pc.size() != 0) begin
            timeouts++;
            $display("timeout: %0d results never committed", exp_pc.size());
        end
        // quiet window, a commit here is an extra one
        repeat (2 * MUL_LATENCY + 10) @(negedge clk);
    endtask

    // commit compare, outputs are registered so the falling edge is stable
    always @(negedge clk) begin : compare
        logic [4:0]  e_rd;
        logic [31:0] e_val;
        logic [31:0] e_pc;
        if (stall) begin
            stall_cycles++;
        end
        if (commit_valid) begin
            commit_count++;
            if (exp_pc.size() == 0) begin
                other_errors++;
                $display("commit of pc %h with no instruction outstanding", commit_pc);
            end else begin
                e_rd  = exp_rd.pop_front();
                e_val = exp_val.pop_front();
                e_pc  = exp_pc.pop_front();
                if (commit_pc !== e_pc) begin
                    value_errors++;
                    $display("[ERROR] %0t commit_pc got %h expected %h", $time, commit_pc, e_pc);
                end
                if (commit_rd !== e_rd) begin
                    value_errors++;
                    $display("[ERROR] %0t commit_rd got %0d expected %0d", $time, commit_rd, e_rd);
                end
                if (commit_data !== e_val) begin
                    value_errors++;
                    $display("[ERROR] %0t commit_data got %h expected %h", $time, commit_data,
                             e_val);
                end
            end
        end
    end

    initial begin
        void'($urandom(32'h70ed_42e2));
        rst          = 1'b1;
        instr_valid  = 1'b0;
        instr_word   = '0;
        instr_pc     = '0;
        next_pc      = 32'h0000_1000;
        value_errors = 0;
        other_errors = 0;
        timeouts     = 0;
        legal_count  = 0;
        commit_count = 0;
        stall_cycles = 0;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        repeat (10) @(negedge clk);
        rst = 1'b0;

        // dependent chains on x1..x4
        send(i_word(12'd5, 5'd0, 3'd0, 5'd1));
        send(r_word(7'h00, 5'd1, 5'd1, 3'd0, 5'd1));
        send(r_word(7'h00, 5'd1, 5'd1, 3'd0, 5'd2));
        send(i_word(12'hffd, 5'd2, 3'd0, 5'd2));
        send(r_word(7'h00, 5'd1, 5'd2, 3'd0, 5'd3));
        send(r_word(7'h20, 5'd2, 5'd3, 3'd0, 5'd4));
        send(r_word(7'h00, 5'd4, 5'd3, 3'd1, 5'd4));
        send(r_word(7'h00, 5'd1, 5'd4, 3'd5, 5'd3));
        // slow mul ahead of independent alu ops
        send(r_word(7'h01, 5'd2, 5'd1, 3'd0, 5'd5));
        send(i_word(12'd7, 5'd0, 3'd6, 5'd6));
        send(i_word(12'd9, 5'd0, 3'd4, 5'd7));
        send(r_word(7'h00, 5'd7, 5'd6, 3'd7, 5'd8));
        // x0 as destination, then read back
        send(i_word(12'd123, 5'd0, 3'd0, 5'd0));
        send(r_word(7'h00, 5'd1, 5'd1, 3'd0, 5'd0));
        send(r_word(7'h00, 5'd0, 5'd0, 3'd0, 5'd9));
        send(r_word(7'h00, 5'd1, 5'd0, 3'd0, 5'd10));
        // x11 written by a fast addi and then a slow mul before the read
        send(i_word(12'd2, 5'd0, 3'd0, 5'd11));
        send(r_word(7'h01, 5'd1, 5'd1, 3'd0, 5'd11));
        send(r_word(7'h00, 5'd11, 5'd11, 3'd0, 5'd12));
        drain();

        repeat (300) send(rand_word());
        drain();

        // mul stream longer than the rob
        send(i_word(12'd3, 5'd0, 3'd0, 5'd14));
        send(i_word(12'd5, 5'd0, 3'd0, 5'd15));
        drain();
        // sources already committed, so only a full rob can stall
        stall_before = stall_cycles;
        repeat (ROB_DEPTH + 4) begin
            send(r_word(7'h01, 5'd14, 5'd15, 3'd0, 5'd16));
            send(r_word(7'h01, 5'd15, 5'd15, 3'd0, 5'd17));
        end
        drain();
        if (stall_cycles == stall_before) begin
            other_errors++;
            $display("stall never rose during the multiply stream");
        end
        if (commit_count != legal_count) begin
            other_errors++;
            $display("%0d commits for %0d legal instructions", commit_count, legal_count);
        end

        $display("errors: value %0d, other %0d, timeout %0d (commits %0d)",
                 value_errors, other_errors, timeouts, commit_count);
        if (value_errors + other_errors + timeouts == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- filelist.f
design/rename_pkg.sv
design/instr_decode.sv
design/rat_arf.sv
design/dispatch_stage.sv
design/exec_units.sv
design/reorder_buffer.sv
design/rename_core_top.sv
verification/rename_core_assert.sv
verification/rename_core_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f filelist.f --top-module rename_core_tb \
    -o rename_core_sim

output=$(./obj_dir/rename_core_sim) || true
echo "$output"

if echo "$output" | grep -qF '*** PASSED ***'; then
    exit 0
fi
exit 1
